// File: verilog/obi_pkg.sv
package obi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Read data word on the response channel
  localparam int unsigned DATA_W = 32;

  // One checksum bit per data byte plus one for err
  localparam int unsigned DATA_BYTES = DATA_W / 8;
  localparam int unsigned RCHK_W     = DATA_BYTES + 1;

  typedef logic [DATA_W-1:0] data_t;

  // Bits 3:0 cover rdata bytes 3:0, bit 4 covers err
  typedef logic [RCHK_W-1:0] rchk_t;

  // Two enables for the checksum compare
  // Bit 0 gates the byte parities and bit 1 gates the err parity
  typedef logic [1:0] rchk_en_t;

  //////////////////////////////////////////////////////////////////////
  // Response channel
  //////////////////////////////////////////////////////////////////////

  // 38 bits in total
  typedef struct packed {
    data_t rdata;
    logic  err;
    rchk_t rchk;
  } obi_resp_t;

  //////////////////////////////////////////////////////////////////////
  // Outstanding transactions
  //////////////////////////////////////////////////////////////////////

  // Default limit on transactions granted but not yet answered
  localparam int unsigned MAX_OUTSTANDING_DEFAULT = 2;

endpackage

// File: verilog/secure_pkg.sv
package secure_pkg;

  //////////////////////////////////////////////////////////////////////
  // Security control
  //////////////////////////////////////////////////////////////////////

  // Bits of cpuctrl not used by the integrity checker
  typedef logic [6:0] cpuctrl_rsvd_t;

  // Integrity enables the response checksum compare
  typedef struct packed {
    logic          integrity;
    cpuctrl_rsvd_t reserved;
  } cpuctrl_t;

  typedef struct packed {
    cpuctrl_t cpuctrl;
  } xsecure_ctrl_t;

  //////////////////////////////////////////////////////////////////////
  // Alerts
  //////////////////////////////////////////////////////////////////////

  // One bit per error source, each a single cycle pulse
  typedef struct packed {
    logic gntpar;
    logic rvalidpar;
    logic rchk;
  } alert_t;

endpackage

// File: verilog/obi_handshake_parity.sv
`timescale 1ns/1ps

module obi_handshake_parity (
  input  logic clk,
  input  logic rst_n,

  // Handshake lines
  input  logic req_i,
  input  logic gnt_i,
  input  logic rvalid_i,

  // Complementary parity lines
  input  logic gntpar_i,
  input  logic rvalidpar_i,

  // Mismatch flags, same cycle as the inputs
  output logic gntpar_err_o,
  output logic rvalidpar_err_o
);

  //////////////////////////////////////////////////////////////////////
  // Parity compare
  //////////////////////////////////////////////////////////////////////

  // Each parity line carries the inverse of its handshake line
  // Equal levels therefore mean a fault on one of the two wires

  // Grant is only meaningful while a request is pending
  assign gntpar_err_o = req_i && (gntpar_i == gnt_i);

  // rvalid is checked in every cycle
  // An idle cycle with a flipped rvalidpar is a fault as well
  assign rvalidpar_err_o = (rvalidpar_i == rvalid_i);

  //////////////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////////////

  // A grant without a request would be counted by nobody downstream
  // and leave the tracking stage out of step with the bus
  a_gnt_needs_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    gnt_i |-> req_i
  ) else $error("gnt_i high without req_i");

endmodule

// File: verilog/obi_rchk_check.sv
`timescale 1ns/1ps

module obi_rchk_check (
  // Response as seen on the bus
  input  obi_pkg::obi_resp_t resp_i,

  // Bit 0 for checksum bits 3:0, bit 1 for bit 4
  input  obi_pkg::rchk_en_t  enable_i,

  // Any enabled checksum bit differs
  output logic               err_o
);

  // Checksum recomputed from the returned data and err
  obi_pkg::rchk_t rchk_calc;

  // Bitwise difference between received and recomputed checksum
  obi_pkg::rchk_t rchk_diff;

  // Mismatch split by enable group
  logic           byte_mismatch;
  logic           err_mismatch;

  //////////////////////////////////////////////////////////////////////
  // Recompute checksum
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Even parity of each data byte
    for (int b = 0; b < int'(obi_pkg::DATA_BYTES); b++) begin
      rchk_calc[b] = ^resp_i.rdata[8*b +: 8];
    end
    // Even parity of a single bit is the bit itself
    rchk_calc[obi_pkg::DATA_BYTES] = resp_i.err;
  end

  assign rchk_diff = rchk_calc ^ resp_i.rchk;

  //////////////////////////////////////////////////////////////////////
  // Compare under enable
  //////////////////////////////////////////////////////////////////////

  // Byte parities are grouped behind one enable
  assign byte_mismatch = |rchk_diff[obi_pkg::DATA_BYTES-1:0];

  // err parity has its own enable
  assign err_mismatch = rchk_diff[obi_pkg::DATA_BYTES];

  assign err_o = (enable_i[0] && byte_mismatch) ||
                 (enable_i[1] && err_mismatch);

endmodule

// File: verilog/obi_integrity_fifo.sv
`timescale 1ns/1ps

module obi_integrity_fifo #(
  parameter int unsigned MAX_OUTSTANDING = obi_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // From the handshake stage
  input  logic                      gntpar_err_i,

  // Attributes of the transaction in the address phase
  input  logic                      trans_integrity_i,
  input  logic                      trans_we_i,

  input  secure_pkg::xsecure_ctrl_t xsecure_ctrl_i,

  // Bus handshake and response
  input  logic                      obi_req_i,
  input  logic                      obi_gnt_i,
  input  logic                      obi_rvalid_i,
  input  obi_pkg::obi_resp_t        obi_resp_i,

  // Attributes of the oldest transaction, valid with rvalid
  output logic                      gntpar_err_resp_o,
  output logic                      integrity_resp_o,
  output logic                      rchk_err_resp_o
);

  // Count must reach MAX_OUTSTANDING itself
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  // What is remembered per outstanding transaction
  typedef struct packed {
    logic integrity;
    logic gnterr;
    logic store;
  } entry_t;

  // Stored entries, newest at 1 and oldest at the count
  entry_t [MAX_OUTSTANDING:1] fifo_q;

  // Stored entries with a constant empty slot at index 0
  entry_t [MAX_OUTSTANDING:0] fifo_view;

  // Stored entries with the incoming one at index 0 ready to shift in
  entry_t [MAX_OUTSTANDING:0] fifo_shift;

  entry_t            fifo_in;
  entry_t            fifo_out;

  cnt_t              cnt_q;
  cnt_t              cnt_d;
  logic              count_up;
  logic              count_down;

  // Sticky gnt parity error across waited grants
  logic              gntpar_err_q;

  obi_pkg::rchk_en_t rchk_en;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  assign count_up   = obi_req_i && obi_gnt_i;
  assign count_down = obi_rvalid_i;

  always_comb begin
    cnt_d = cnt_q;
    // Grant and response together leave the count unchanged
    if (count_up && !count_down) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!count_up && count_down) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky gnt parity error
  //////////////////////////////////////////////////////////////////////

  // Collect errors while the request waits, drop them at the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gntpar_err_q <= 1'b0;
    end else if (obi_req_i) begin
      if (obi_gnt_i) begin
        gntpar_err_q <= 1'b0;
      end else begin
        gntpar_err_q <= gntpar_err_q || gntpar_err_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Attribute FIFO
  //////////////////////////////////////////////////////////////////////

  // Error of the grant cycle itself counts too
  assign fifo_in.integrity = trans_integrity_i;
  assign fifo_in.gnterr    = gntpar_err_q || gntpar_err_i;
  assign fifo_in.store     = trans_we_i;

  assign fifo_shift = {fifo_q, fifo_in};
  assign fifo_view  = {fifo_q, entry_t'('0)};

  // Every grant shifts all entries one place towards the old end
  always_ff @(posedge clk) begin
    if (count_up) begin
      fifo_q <= fifo_shift[MAX_OUTSTANDING-1:0];
    end
  end

  // Count points straight at the oldest entry
  assign fifo_out = fifo_view[cnt_q];

  assign integrity_resp_o  = fifo_out.integrity;
  assign gntpar_err_resp_o = fifo_out.gnterr;

  //////////////////////////////////////////////////////////////////////
  // Response checksum
  //////////////////////////////////////////////////////////////////////

  // Stores return no data so only the err parity is checked for them
  assign rchk_en[0] = obi_rvalid_i && xsecure_ctrl_i.cpuctrl.integrity && !fifo_out.store;
  assign rchk_en[1] = obi_rvalid_i && xsecure_ctrl_i.cpuctrl.integrity;

  obi_rchk_check rchk_check_i (
    .resp_i   (obi_resp_i),
    .enable_i (rchk_en),
    .err_o    (rchk_err_resp_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Counter limits
  //////////////////////////////////////////////////////////////////////

  // Bus has no back-pressure so the environment must respect the depth
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (cnt_q == cnt_t'(MAX_OUTSTANDING)) |-> !(count_up && !count_down)
  ) else $error("More than MAX_OUTSTANDING transactions granted");

  // A response needs a granted transaction from an earlier cycle
  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (cnt_q == '0) |-> !count_down
  ) else $error("rvalid_i with nothing outstanding");

endmodule

// File: verilog/obi_integrity_alert.sv
`timescale 1ns/1ps

module obi_integrity_alert (
  input  logic               clk,
  input  logic               rst_n,

  // Response cycle from the bus
  input  logic               rvalid_i,
  input  obi_pkg::obi_resp_t resp_i,

  // Attributes and errors of the response, same cycle as rvalid
  input  logic               integrity_resp_i,
  input  logic               gntpar_err_resp_i,
  input  logic               rchk_err_i,

  // Handshake parity fault in any cycle
  input  logic               rvalidpar_err_i,

  // Registered response towards the core
  output logic               resp_valid_o,
  output obi_pkg::data_t     resp_rdata_o,
  output logic               resp_err_o,
  output logic               resp_integrity_o,

  output secure_pkg::alert_t alert_major_o
);

  secure_pkg::alert_t alert_d;
  secure_pkg::alert_t alert_q;

  //////////////////////////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////////////////////////

  // Valid is a single cycle per response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= rvalid_i;
    end
  end

  // Payload only loads on a response and holds in between
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_rdata_o     <= '0;
      resp_err_o       <= 1'b0;
      resp_integrity_o <= 1'b0;
    end else if (rvalid_i) begin
      resp_rdata_o     <= resp_i.rdata;
      resp_err_o       <= resp_i.err;
      resp_integrity_o <= integrity_resp_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Alerts
  //////////////////////////////////////////////////////////////////////

  // gnt error only counts when its transaction is answered
  assign alert_d.gntpar    = rvalid_i && gntpar_err_resp_i;
  assign alert_d.rchk      = rvalid_i && rchk_err_i;
  // rvalid parity fault is reported even in idle cycles
  assign alert_d.rvalidpar = rvalidpar_err_i;

  // Recomputed every cycle so each alert is a one cycle pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alert_q <= '0;
    end else begin
      alert_q <= alert_d;
    end
  end

  assign alert_major_o = alert_q;

endmodule

// File: verilog/obi_integrity_top.sv
`timescale 1ns/1ps

module obi_integrity_top #(
  parameter int unsigned MAX_OUTSTANDING = obi_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Bus handshake with parity
  input  logic                      req_i,
  input  logic                      gnt_i,
  input  logic                      gntpar_i,
  input  logic                      rvalid_i,
  input  logic                      rvalidpar_i,
  input  obi_pkg::obi_resp_t        resp_i,

  // Transaction attributes, valid with req_i
  input  logic                      we_i,
  input  logic                      integrity_i,

  input  secure_pkg::xsecure_ctrl_t xsecure_ctrl_i,

  // Registered response and alerts
  output logic                      resp_valid_o,
  output obi_pkg::data_t            resp_rdata_o,
  output logic                      resp_integrity_o,
  output logic                      resp_err_o,
  output secure_pkg::alert_t        alert_major_o
);

  // Handshake stage results
  logic gntpar_err;
  logic rvalidpar_err;

  // Tracking stage results in the rvalid cycle
  logic gntpar_err_resp;
  logic integrity_resp;
  logic rchk_err_resp;

  obi_handshake_parity handshake_parity_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .gnt_i           (gnt_i),
    .rvalid_i        (rvalid_i),
    .gntpar_i        (gntpar_i),
    .rvalidpar_i     (rvalidpar_i),
    .gntpar_err_o    (gntpar_err),
    .rvalidpar_err_o (rvalidpar_err)
  );

  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) integrity_fifo_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .gntpar_err_i      (gntpar_err),
    .trans_integrity_i (integrity_i),
    .trans_we_i        (we_i),
    .xsecure_ctrl_i    (xsecure_ctrl_i),
    .obi_req_i         (req_i),
    .obi_gnt_i         (gnt_i),
    .obi_rvalid_i      (rvalid_i),
    .obi_resp_i        (resp_i),
    .gntpar_err_resp_o (gntpar_err_resp),
    .integrity_resp_o  (integrity_resp),
    .rchk_err_resp_o   (rchk_err_resp)
  );

  obi_integrity_alert integrity_alert_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .rvalid_i          (rvalid_i),
    .resp_i            (resp_i),
    .integrity_resp_i  (integrity_resp),
    .gntpar_err_resp_i (gntpar_err_resp),
    .rchk_err_i        (rchk_err_resp),
    .rvalidpar_err_i   (rvalidpar_err),
    .resp_valid_o      (resp_valid_o),
    .resp_rdata_o      (resp_rdata_o),
    .resp_err_o        (resp_err_o),
    .resp_integrity_o  (resp_integrity_o),
    .alert_major_o     (alert_major_o)
  );

endmodule

// File: test/obi_integrity_tb.sv
`timescale 1ns/1ps

module obi_integrity_tb;

  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int          CLK_HALF        = 20;
  localparam int          DRIVE_DELAY     = 2;
  // Compare point sits 3 ns before the next rising edge
  localparam int          SAMPLE_DELAY    = 35;
  localparam int          NUM_COLS        = 17;
  localparam string       STIM_FILE       = "test/obi_integrity_stimulus.txt";

  // One stimulus line, inputs first and then the next cycle's outputs
  typedef struct packed {
    logic               req;
    logic               gnt;
    logic               gntpar;
    logic               rvalid;
    logic               rvalidpar;
    logic               we;
    logic               integrity;
    logic               cpu_integrity;
    logic               rnd;
    obi_pkg::data_t     rdata;
    logic               err;
    obi_pkg::rchk_t     flip;
    logic               exp_valid;
    obi_pkg::data_t     exp_rdata;
    logic               exp_integrity;
    logic               exp_err;
    secure_pkg::alert_t exp_alert;
  } vec_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      req;
  logic                      gnt;
  logic                      gntpar;
  logic                      rvalid;
  logic                      rvalidpar;
  logic                      we;
  logic                      integrity;
  obi_pkg::obi_resp_t        resp;
  secure_pkg::xsecure_ctrl_t xsecure_ctrl;

  logic                      resp_valid;
  obi_pkg::data_t            resp_rdata;
  logic                      resp_integrity;
  logic                      resp_err;
  secure_pkg::alert_t        alert_major;

  vec_t                      vec_q[$];
  vec_t                      cur;
  vec_t                      pend;
  integer                    seed;
  int                        cycle_cnt = 0;
  int                        cycle_limit = 0;

  always #(CLK_HALF) clk = ~clk;

  obi_integrity_top #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_i            (req),
    .gnt_i            (gnt),
    .gntpar_i         (gntpar),
    .rvalid_i         (rvalid),
    .rvalidpar_i      (rvalidpar),
    .resp_i           (resp),
    .we_i             (we),
    .integrity_i      (integrity),
    .xsecure_ctrl_i   (xsecure_ctrl),
    .resp_valid_o     (resp_valid),
    .resp_rdata_o     (resp_rdata),
    .resp_integrity_o (resp_integrity),
    .resp_err_o       (resp_err),
    .alert_major_o    (alert_major)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_data(input string name, input obi_pkg::data_t exp,
                            input obi_pkg::data_t act);
    if (act !== exp)
      stop_run($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_run($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_alert(input secure_pkg::alert_t exp, input secure_pkg::alert_t act);
    if (act !== exp)
      stop_run($sformatf("[FAIL] alert_major_o expected %h got %h", exp, act));
  endtask

  // Payload is only defined in a response cycle
  task automatic check_outputs(input vec_t v);
    check_flag("resp_valid_o", v.exp_valid, resp_valid);
    if (v.exp_valid) begin
      check_data("resp_rdata_o", v.exp_rdata, resp_rdata);
      check_flag("resp_integrity_o", v.exp_integrity, resp_integrity);
      check_flag("resp_err_o", v.exp_err, resp_err);
    end
    check_alert(v.exp_alert, alert_major);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Even parity per byte, bit 4 is err itself
  function automatic obi_pkg::rchk_t rchk_of(input obi_pkg::data_t data, input logic err);
    obi_pkg::rchk_t r;
    for (int b = 0; b < 4; b++) begin
      r[b] = ^data[8*b +: 8];
    end
    r[4] = err;
    return r;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [NUM_COLS];
    vec_t        v;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stop_run($sformatf("Could not open stimulus file %s", STIM_FILE));
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Skip blank lines and column notes
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                      col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                      col[15], col[16]);
          if (n != NUM_COLS) begin
            stop_run($sformatf("Stimulus line has %0d fields: %s", n, line));
          end else begin
            v = {col[0][0], col[1][0], col[2][0], col[3][0], col[4][0], col[5][0],
                 col[6][0], col[7][0], col[8][0], col[9], col[10][0], col[11][4:0],
                 col[12][0], col[13], col[14][0], col[15][0], col[16][2:0]};
            vec_q.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Parity lines correct, nothing on the bus
  task automatic drive_idle();
    req          = 1'b0;
    gnt          = 1'b0;
    gntpar       = 1'b1;
    rvalid       = 1'b0;
    rvalidpar    = 1'b1;
    we           = 1'b0;
    integrity    = 1'b0;
    resp         = '0;
    xsecure_ctrl = '0;
  endtask

  // Clean lines get random data, expected data follows it
  task automatic drive_vector(inout vec_t v);
    obi_pkg::data_t data;
    data = v.rnd ? obi_pkg::data_t'($random(seed)) : v.rdata;
    if (v.rnd)
      v.exp_rdata = data;
    req                                  = v.req;
    gnt                                  = v.gnt;
    gntpar                               = v.gntpar;
    rvalid                               = v.rvalid;
    rvalidpar                            = v.rvalidpar;
    we                                   = v.we;
    integrity                            = v.integrity;
    xsecure_ctrl                         = '0;
    xsecure_ctrl.cpuctrl.integrity       = v.cpu_integrity;
    resp.rdata                           = data;
    resp.err                             = v.err;
    resp.rchk                            = rchk_of(data, v.err) ^ v.flip;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit)
      stop_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
  end

  initial begin
    seed  = 32'he3df;
    rst_n = 1'b0;
    drive_idle();
    load_vectors();
    // Reset, every line, one trailing cycle and some margin
    cycle_limit = vec_q.size() + 20;
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY) rst_n = 1'b1;
    // Each pass drives line i and checks line i-1
    for (int i = 0; i <= vec_q.size(); i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      if (i < vec_q.size()) begin
        cur = vec_q[i];
        drive_vector(cur);
      end else begin
        drive_idle();
      end
      #(SAMPLE_DELAY);
      if (i > 0)
        check_outputs(pend);
      pend = cur;
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: test/obi_integrity_stimulus.txt
# req gnt gntpar rvalid rvalidpar we integrity cpu_integrity rnd rdata err rchk_flip
# next cycle: valid rdata integrity err alert (gntpar=4 rvalidpar=2 rchk=1), all hex
0 0 1 0 1 0 0 1 0 00000000 0 00 0 00000000 0 0 0
1 1 0 0 1 0 1 1 0 00000000 0 00 0 00000000 0 0 0
1 1 0 1 0 0 0 1 1 00000000 0 00 1 00000000 1 0 0
0 0 1 1 0 0 0 1 1 00000000 0 00 1 00000000 0 0 0
0 0 1 0 1 0 0 1 0 00000000 0 00 0 00000000 0 0 0
# waited grant with a gntpar fault in the first waiting cycle
1 0 0 0 1 0 1 1 0 00000000 0 00 0 00000000 0 0 0
1 0 1 0 1 0 1 1 0 00000000 0 00 0 00000000 0 0 0
1 1 0 0 1 0 1 1 0 00000000 0 00 0 00000000 0 0 0
0 0 1 1 0 0 0 1 1 00000000 0 00 1 00000000 1 0 4
1 1 0 0 1 0 0 1 0 00000000 0 00 0 00000000 0 0 0
0 0 1 1 0 0 0 1 1 00000000 0 00 1 00000000 0 0 0
# load with a bad byte parity, checked and then unchecked
1 1 0 0 1 0 1 1 0 00000000 0 00 0 00000000 0 0 0
0 0 1 1 0 0 0 1 0 a5a5f00f 0 01 1 a5a5f00f 1 0 1
1 1 0 0 1 0 1 0 0 00000000 0 00 0 00000000 0 0 0
0 0 1 1 0 0 0 0 0 a5a5f00f 0 01 1 a5a5f00f 1 0 0
# store with a bad byte parity, then with a bad err parity
1 1 0 0 1 1 1 1 0 00000000 0 00 0 00000000 0 0 0
0 0 1 1 0 0 0 1 0 12345678 0 04 1 12345678 1 0 0
1 1 0 0 1 1 0 1 0 00000000 0 00 0 00000000 0 0 0
0 0 1 1 0 0 0 1 0 00000000 1 10 1 00000000 0 1 1
# rvalidpar fault while idle
0 0 1 0 0 0 0 1 0 00000000 0 00 0 00000000 0 0 2
0 0 1 0 1 0 0 1 0 00000000 0 00 0 00000000 0 0 0
# two outstanding, grant and rvalid together
1 1 0 0 1 0 1 1 0 00000000 0 00 0 00000000 0 0 0
1 1 0 0 1 0 0 1 0 00000000 0 00 0 00000000 0 0 0
1 1 0 1 0 0 1 1 1 00000000 0 00 1 00000000 1 0 0
0 0 1 1 0 0 0 1 1 00000000 0 00 1 00000000 0 0 0
0 0 1 1 0 0 0 1 1 00000000 0 00 1 00000000 1 0 0
0 0 1 0 1 0 0 1 0 00000000 0 00 0 00000000 0 0 0

// File: project.f
verilog/obi_pkg.sv
verilog/secure_pkg.sv
verilog/obi_handshake_parity.sv
verilog/obi_rchk_check.sv
verilog/obi_integrity_fifo.sv
verilog/obi_integrity_alert.sv
verilog/obi_integrity_top.sv
test/obi_integrity_tb.sv
